// File: hw/conv_ctrl.sv
module conv_ctrl #(
    parameter int KERNEL_TAPS = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_start,
    input  conv_pkg::line_len_t i_line_len,
    input  conv_pkg::line_len_t i_line_count,
    input  logic                i_weight_val,
    input  logic                i_data_val,
    output logic                o_weight_req,
    output logic                o_weight_load,
    output logic                o_data_req,
    output logic                o_shift,
    output logic                o_emit,
    output logic                o_last,
    output logic                o_busy,
    output logic                o_done
);
    import conv_pkg::*;

    localparam int TAP_CNT_W = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1;

    conv_state_e          state;
    conv_state_e          state_nxt;
    logic [TAP_CNT_W-1:0] tap_cnt;
    line_len_t            col_cnt;
    line_len_t            line_cnt;
    logic                 beat_xfer;
    logic                 pix_xfer;
    logic                 last_beat;
    logic                 last_col;
    logic                 last_line;

    //////////////////////////////////////////////////
    // Handshakes
    assign o_weight_req = (state == LOAD_W);
    assign o_data_req   = (state == RUN);
    assign beat_xfer    = o_weight_req & i_weight_val;
    assign pix_xfer     = o_data_req & i_data_val;

    assign last_beat = (tap_cnt == TAP_CNT_W'(KERNEL_TAPS - 1));
    assign last_col  = (col_cnt == i_line_len - 1'b1);
    assign last_line = (line_cnt == i_line_count - 1'b1);

    // Flags travel with the accepted pixel
    assign o_weight_load = beat_xfer;
    assign o_shift       = pix_xfer;
    // Window is full once KERNEL_TAPS pixels of this line are in
    assign o_emit        = (col_cnt >= line_len_t'(KERNEL_TAPS - 1));
    assign o_last        = last_col;

    assign o_busy = (state == LOAD_W) || (state == RUN);
    assign o_done = (state == DONE);

    //////////////////////////////////////////////////
    // State machine
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: begin
                if (i_start) begin
                    state_nxt = LOAD_W;
                end
            end
            LOAD_W: begin
                if (beat_xfer && last_beat) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (pix_xfer && last_col && last_line) begin
                    state_nxt = DONE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Weight beat count
    always_ff @(posedge clk) begin
        if (rst) begin
            tap_cnt <= '0;
        end else if (i_start) begin
            tap_cnt <= '0;
        end else if (beat_xfer) begin
            tap_cnt <= last_beat ? '0 : tap_cnt + 1'b1;
        end
    end

    // Column and line position, cleared while weights load
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt  <= '0;
            line_cnt <= '0;
        end else if (state == LOAD_W) begin
            col_cnt  <= '0;
            line_cnt <= '0;
        end else if (pix_xfer) begin
            if (last_col) begin
                col_cnt  <= '0;
                line_cnt <= last_line ? '0 : line_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/conv_pkg.sv
package conv_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    localparam int CHAN_W      = 8;
    localparam int NUM_CHANNEL = 3;
    localparam int NUM_KERNEL  = 4;
    localparam int PSUM_W      = 20;
    localparam int PIXEL_W     = CHAN_W * NUM_CHANNEL;
    localparam int WEIGHT_W    = PIXEL_W * NUM_KERNEL;
    localparam int LINE_LEN_W  = 16;
    localparam int APB_ADDR_W  = 4;
    localparam int APB_DATA_W  = 32;

    typedef logic [CHAN_W-1:0]     chan_t;
    // Channel c sits at byte c
    typedef logic [PIXEL_W-1:0]    pixel_t;
    // Kernel k, channel c sits at byte k*3+c
    typedef logic [WEIGHT_W-1:0]   weight_beat_t;
    typedef logic [PSUM_W-1:0]     psum_t;
    typedef logic [LINE_LEN_W-1:0] line_len_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    //////////////////////////////////////////////////
    // Register map
    localparam apb_addr_t REG_CTRL       = 4'h0;
    localparam apb_addr_t REG_LINE_LEN   = 4'h4;
    localparam apb_addr_t REG_LINE_COUNT = 4'h8;
    localparam apb_addr_t REG_STATUS     = 4'hC;

    typedef enum logic [1:0] {IDLE, LOAD_W, RUN, DONE} conv_state_e;

endpackage

// File: hw/conv_regs.sv
module conv_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_psel,
    input  logic                            i_penable,
    input  logic                            i_pwrite,
    input  conv_pkg::apb_addr_t             i_paddr,
    input  logic [conv_pkg::APB_DATA_W-1:0] i_pwdata,
    output logic [conv_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                            o_pready,
    output logic                            o_pslverr,
    input  logic                            i_busy,
    input  logic                            i_done,
    output logic                            o_start,
    output conv_pkg::line_len_t             o_line_len,
    output conv_pkg::line_len_t             o_line_count
);
    import conv_pkg::*;

    logic access;
    logic wr_en;
    logic addr_hit;

    // Access phase of any transfer
    assign access = i_psel & i_penable;
    assign wr_en  = access & i_pwrite;

    always_comb begin
        case (i_paddr)
            REG_CTRL, REG_LINE_LEN, REG_LINE_COUNT, REG_STATUS: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    // No wait states
    assign o_pready  = 1'b1;
    assign o_pslverr = access & ~addr_hit;

    //////////////////////////////////////////////////
    // Configuration registers
    always_ff @(posedge clk) begin
        if (rst) begin
            o_line_len   <= '0;
            o_line_count <= '0;
        end else if (wr_en) begin
            if (i_paddr == REG_LINE_LEN) begin
                o_line_len <= line_len_t'(i_pwdata);
            end
            if (i_paddr == REG_LINE_COUNT) begin
                o_line_count <= line_len_t'(i_pwdata);
            end
        end
    end

    // Start pulse, dropped while a run is going
    always_ff @(posedge clk) begin
        if (rst) begin
            o_start <= 1'b0;
        end else begin
            o_start <= wr_en & (i_paddr == REG_CTRL) & i_pwdata[0] & ~i_busy;
        end
    end

    // Read mux, CTRL reads back as zero
    always_comb begin
        case (i_paddr)
            REG_LINE_LEN:   o_prdata = APB_DATA_W'(o_line_len);
            REG_LINE_COUNT: o_prdata = APB_DATA_W'(o_line_count);
            REG_STATUS:     o_prdata = APB_DATA_W'({i_busy, i_done});
            default:        o_prdata = '0;
        endcase
    end

endmodule

// File: hw/kernel_mac_array.sv
module kernel_mac_array #(
    parameter int KERNEL_TAPS = 3
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  conv_pkg::pixel_t       [KERNEL_TAPS-1:0]     i_window,
    input  conv_pkg::weight_beat_t [KERNEL_TAPS-1:0]     i_weights,
    input  logic                                         i_win_val,
    input  logic                                         i_win_last,
    output conv_pkg::psum_t [conv_pkg::NUM_KERNEL-1:0]   o_psum,
    output logic                                         o_psum_val,
    output logic                                         o_psum_end
);
    import conv_pkg::*;

    psum_t kernel_sum [NUM_KERNEL];

    //////////////////////////////////////////////////
    // One adder tree per kernel
    for (genvar k = 0; k < NUM_KERNEL; k++) begin : g_kernel
        always_comb begin
            chan_t               pix_c;
            chan_t               wgt_c;
            logic [2*CHAN_W-1:0] prod;
            kernel_sum[k] = '0;
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                for (int c = 0; c < NUM_CHANNEL; c++) begin
                    pix_c = i_window[t][c*CHAN_W +: CHAN_W];
                    wgt_c = i_weights[t][(k*NUM_CHANNEL + c)*CHAN_W +: CHAN_W];
                    prod  = pix_c * wgt_c;
                    // 5 taps of 3 channels still fit in PSUM_W
                    kernel_sum[k] = kernel_sum[k] + psum_t'(prod);
                end
            end
        end
    end

    // Result register, loaded only for full windows
    always_ff @(posedge clk) begin
        if (i_win_val) begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                o_psum[k] <= kernel_sum[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_val <= 1'b0;
            o_psum_end <= 1'b0;
        end else begin
            o_psum_val <= i_win_val;
            o_psum_end <= i_win_last;
        end
    end

endmodule

// File: hw/line_conv_top.sv
module line_conv_top #(
    parameter int KERNEL_TAPS = 3
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       i_psel,
    input  logic                                       i_penable,
    input  logic                                       i_pwrite,
    input  conv_pkg::apb_addr_t                        i_paddr,
    input  logic [conv_pkg::APB_DATA_W-1:0]            i_pwdata,
    output logic [conv_pkg::APB_DATA_W-1:0]            o_prdata,
    output logic                                       o_pready,
    output logic                                       o_pslverr,
    input  conv_pkg::weight_beat_t                     i_weight,
    input  logic                                       i_weight_val,
    output logic                                       o_weight_req,
    input  conv_pkg::pixel_t                           i_data,
    input  logic                                       i_data_val,
    output logic                                       o_data_req,
    output conv_pkg::psum_t [conv_pkg::NUM_KERNEL-1:0] o_psum,
    output logic                                       o_psum_val,
    output logic                                       o_psum_end,
    output logic                                       o_done
);
    import conv_pkg::*;

    logic                           start;
    logic                           busy;
    line_len_t                      line_len;
    line_len_t                      line_count;
    logic                           weight_load;
    logic                           shift;
    logic                           emit;
    logic                           last;
    weight_beat_t [KERNEL_TAPS-1:0] weights;
    pixel_t       [KERNEL_TAPS-1:0] window;
    logic                           win_val;
    logic                           win_last;

    //////////////////////////////////////////////////
    // Control side
    conv_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .i_busy       (busy),
        .i_done       (o_done),
        .o_start      (start),
        .o_line_len   (line_len),
        .o_line_count (line_count)
    );

    conv_ctrl #(.KERNEL_TAPS(KERNEL_TAPS)) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_start       (start),
        .i_line_len    (line_len),
        .i_line_count  (line_count),
        .i_weight_val  (i_weight_val),
        .i_data_val    (i_data_val),
        .o_weight_req  (o_weight_req),
        .o_weight_load (weight_load),
        .o_data_req    (o_data_req),
        .o_shift       (shift),
        .o_emit        (emit),
        .o_last        (last),
        .o_busy        (busy),
        .o_done        (o_done)
    );

    //////////////////////////////////////////////////
    // Datapath
    weight_store #(.KERNEL_TAPS(KERNEL_TAPS)) u_weights (
        .clk       (clk),
        .rst       (rst),
        .i_load    (weight_load),
        .i_weight  (i_weight),
        .o_weights (weights)
    );

    pixel_window #(.KERNEL_TAPS(KERNEL_TAPS)) u_window (
        .clk        (clk),
        .rst        (rst),
        .i_shift    (shift),
        .i_emit     (emit),
        .i_last     (last),
        .i_data     (i_data),
        .o_window   (window),
        .o_win_val  (win_val),
        .o_win_last (win_last)
    );

    kernel_mac_array #(.KERNEL_TAPS(KERNEL_TAPS)) u_mac (
        .clk        (clk),
        .rst        (rst),
        .i_window   (window),
        .i_weights  (weights),
        .i_win_val  (win_val),
        .i_win_last (win_last),
        .o_psum     (o_psum),
        .o_psum_val (o_psum_val),
        .o_psum_end (o_psum_end)
    );

endmodule

// File: hw/pixel_window.sv
module pixel_window #(
    parameter int KERNEL_TAPS = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_shift,
    input  logic                               i_emit,
    input  logic                               i_last,
    input  conv_pkg::pixel_t                   i_data,
    output conv_pkg::pixel_t [KERNEL_TAPS-1:0] o_window,
    output logic                               o_win_val,
    output logic                               o_win_last
);
    import conv_pkg::*;

    pixel_t [KERNEL_TAPS-1:0] win;

    //////////////////////////////////////////////////
    // Sliding window, tap 0 is the oldest pixel
    always_ff @(posedge clk) begin
        if (i_shift) begin
            win[KERNEL_TAPS-1] <= i_data;
            for (int t = 0; t < KERNEL_TAPS - 1; t++) begin
                win[t] <= win[t+1];
            end
        end
    end

    assign o_window = win;

    // Flags line up with the window they describe
    always_ff @(posedge clk) begin
        if (rst) begin
            o_win_val  <= 1'b0;
            o_win_last <= 1'b0;
        end else begin
            // Partially filled windows never reach the MACs
            o_win_val  <= i_shift & i_emit;
            o_win_last <= i_shift & i_emit & i_last;
        end
    end

endmodule

// File: hw/weight_store.sv
module weight_store #(
    parameter int KERNEL_TAPS = 3
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     i_load,
    input  conv_pkg::weight_beat_t                   i_weight,
    output conv_pkg::weight_beat_t [KERNEL_TAPS-1:0] o_weights
);
    import conv_pkg::*;

    weight_beat_t [KERNEL_TAPS-1:0] taps;

    //////////////////////////////////////////////////
    // Tap shift register
    // New beats enter at the top and move toward tap 0,
    // so the first beat of a load ends up in tap 0
    always_ff @(posedge clk) begin
        if (rst) begin
            taps <= '0;
        end else if (i_load) begin
            taps[KERNEL_TAPS-1] <= i_weight;
            for (int t = 0; t < KERNEL_TAPS - 1; t++) begin
                taps[t] <= taps[t+1];
            end
        end
    end

    // Held steady for the whole run
    assign o_weights = taps;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the line convolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_line_conv \
    -f verilog.f \
    -o tb_line_conv

./obj_dir/tb_line_conv

// File: sim/tb_line_conv.sv
module tb_line_conv;
    timeunit 1ns;
    timeprecision 1ps;

    import conv_pkg::*;

    localparam int KERNEL_TAPS     = 3;
    localparam int RUN1_LEN        = 8;
    localparam int RUN1_LINES      = 3;
    localparam int RUN2_LEN        = 12;
    localparam int RUN2_LINES      = 2;
    localparam int TOTAL_PIXELS    = RUN1_LEN * RUN1_LINES + RUN2_LEN * RUN2_LINES;
    localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 4 + 2000;

    logic                     clk;
    logic                     rst;
    logic                     i_psel;
    logic                     i_penable;
    logic                     i_pwrite;
    apb_addr_t                i_paddr;
    logic [APB_DATA_W-1:0]    i_pwdata;
    logic [APB_DATA_W-1:0]    o_prdata;
    logic                     o_pready;
    logic                     o_pslverr;
    weight_beat_t             i_weight;
    logic                     i_weight_val;
    logic                     o_weight_req;
    pixel_t                   i_data;
    logic                     i_data_val;
    logic                     o_data_req;
    psum_t [NUM_KERNEL-1:0]   o_psum;
    logic                     o_psum_val;
    logic                     o_psum_end;
    logic                     o_done;

    // Reference model state
    weight_beat_t                 wbeat [KERNEL_TAPS];
    pixel_t                       model_win [KERNEL_TAPS];
    int                           model_col;
    int                           cur_len;
    logic [NUM_KERNEL*PSUM_W-1:0] exp_q [$];
    logic                         end_q [$];

    line_conv_top #(.KERNEL_TAPS(KERNEL_TAPS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////
    // Checking helpers
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail at %0d ns: %s expected %0h, actual %0h", $time, name,
                     expected, actual);
            abort_run("Value mismatch, stopping");
        end
    endtask

    //////////////////////////////////////////////////
    // APB master
    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #2;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(posedge clk);
        #2;
        i_penable = 1'b1;
        @(negedge clk);
        check("o_pready", 1, o_pready);
        err = o_pslverr;
        @(posedge clk);
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #2;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(posedge clk);
        #2;
        i_penable = 1'b1;
        @(negedge clk);
        check("o_pready", 1, o_pready);
        data = o_prdata;
        err  = o_pslverr;
        @(posedge clk);
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Reference model fed one accepted pixel at a time
    task automatic model_pixel(input pixel_t pix);
        logic [NUM_KERNEL*PSUM_W-1:0] row;
        logic [31:0]                  sum;
        logic [7:0]                   pix_c;
        logic [7:0]                   wgt_c;
        for (int t = 0; t < KERNEL_TAPS - 1; t++) begin
            model_win[t] = model_win[t+1];
        end
        model_win[KERNEL_TAPS-1] = pix;
        // Only full windows of the current line give a result
        if (model_col >= KERNEL_TAPS - 1) begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                sum = 0;
                for (int t = 0; t < KERNEL_TAPS; t++) begin
                    for (int c = 0; c < NUM_CHANNEL; c++) begin
                        pix_c = model_win[t][c*8 +: 8];
                        wgt_c = wbeat[t][(k*3 + c)*8 +: 8];
                        sum   = sum + 32'(pix_c) * 32'(wgt_c);
                    end
                end
                row[k*PSUM_W +: PSUM_W] = sum[PSUM_W-1:0];
            end
            exp_q.push_back(row);
            end_q.push_back(model_col == cur_len - 1);
        end
        model_col = (model_col == cur_len - 1) ? 0 : model_col + 1;
    endtask

    //////////////////////////////////////////////////
    // Stream sources with random stalls
    task automatic load_weights();
        int   beats;
        logic seen_req;
        logic xfer;
        beats    = 0;
        seen_req = 1'b0;
        @(posedge clk);
        #2;
        while (beats < KERNEL_TAPS) begin
            i_weight_val = ($urandom_range(0, 3) != 0);
            i_weight     = i_weight_val ? wbeat[beats] : {$urandom, $urandom, $urandom};
            @(negedge clk);
            check("o_data_req", 0, o_data_req);
            if (seen_req) begin
                check("o_weight_req", 1, o_weight_req);
            end else if (o_weight_req) begin
                // A new start has cleared done
                check("o_done", 0, o_done);
            end
            seen_req = seen_req | o_weight_req;
            xfer     = o_weight_req & i_weight_val;
            @(posedge clk);
            #2;
            if (xfer) begin
                beats++;
            end
        end
        i_weight_val = 1'b0;
        @(negedge clk);
        check("o_weight_req", 0, o_weight_req);
    endtask

    task automatic feed_pixels(input int total);
        int     p;
        logic   xfer;
        pixel_t pix;
        p   = 0;
        pix = pixel_t'($urandom);
        @(posedge clk);
        #2;
        while (p < total) begin
            i_data_val = ($urandom_range(0, 3) != 0);
            i_data     = i_data_val ? pix : pixel_t'($urandom);
            @(negedge clk);
            check("o_weight_req", 0, o_weight_req);
            xfer = o_data_req & i_data_val;
            @(posedge clk);
            #2;
            if (xfer) begin
                model_pixel(pix);
                p++;
                pix = pixel_t'($urandom);
            end
        end
        i_data_val = 1'b0;
    endtask

    // One full convolution run with fresh weights
    task automatic run_conv(input int len, input int lines);
        logic [31:0] rd;
        logic        err;
        cur_len    = len;
        model_col  = 0;
        apb_write(REG_LINE_LEN, len, err);
        check("o_pslverr", 0, err);
        apb_write(REG_LINE_COUNT, lines, err);
        check("o_pslverr", 0, err);
        apb_read(REG_LINE_LEN, rd, err);
        check("LINE_LEN", len, rd);
        apb_read(REG_LINE_COUNT, rd, err);
        check("LINE_COUNT", lines, rd);
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            wbeat[t] = {$urandom, $urandom, $urandom};
        end
        apb_write(REG_CTRL, 32'h1, err);
        check("o_pslverr", 0, err);
        load_weights();
        apb_read(REG_STATUS, rd, err);
        check("STATUS", 32'h2, rd);
        feed_pixels(len * lines);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        check("o_done", 1, o_done);
        check("o_data_req", 0, o_data_req);
        apb_read(REG_STATUS, rd, err);
        check("STATUS", 32'h1, rd);
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    initial begin
        int                           line_outs;
        logic [NUM_KERNEL*PSUM_W-1:0] row;
        logic                         exp_end;
        line_outs = 0;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (o_psum_val === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("A psum came out that the model did not expect");
                end
                row     = exp_q.pop_front();
                exp_end = end_q.pop_front();
                for (int k = 0; k < NUM_KERNEL; k++) begin
                    check($sformatf("o_psum[%0d]", k), row[k*PSUM_W +: PSUM_W], o_psum[k]);
                end
                line_outs++;
                if (o_psum_end) begin
                    check("outputs per line", cur_len - KERNEL_TAPS + 1, line_outs);
                    line_outs = 0;
                end
                check("o_psum_end", exp_end, o_psum_end);
            end else begin
                check("o_psum_end", 0, o_psum_end);
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        logic [31:0] rd;
        logic        err;
        void'($urandom(32'h7e39));
        rst          = 1'b1;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_weight     = '0;
        i_weight_val = 1'b0;
        i_data       = '0;
        i_data_val   = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle state after reset
        @(negedge clk);
        check("o_data_req", 0, o_data_req);
        check("o_weight_req", 0, o_weight_req);
        check("o_psum_val", 0, o_psum_val);
        check("o_done", 0, o_done);
        check("o_pslverr", 0, o_pslverr);
        apb_read(REG_STATUS, rd, err);
        check("STATUS", 0, rd);
        check("o_pslverr", 0, err);
        apb_read(REG_LINE_LEN, rd, err);
        check("LINE_LEN", 0, rd);
        apb_read(REG_LINE_COUNT, rd, err);
        check("LINE_COUNT", 0, rd);
        apb_read(4'h1, rd, err);
        check("o_pslverr", 1, err);

        run_conv(RUN1_LEN, RUN1_LINES);
        run_conv(RUN2_LEN, RUN2_LINES);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verilog.f
hw/conv_pkg.sv
hw/conv_regs.sv
hw/conv_ctrl.sv
hw/weight_store.sv
hw/pixel_window.sv
hw/kernel_mac_array.sv
hw/line_conv_top.sv
sim/tb_line_conv.sv
